// File: sim.f
src/mips_exc_pkg.sv
src/exec_slot_if.sv
src/exc_flags_if.sv
src/exc_collector.sv
src/exhandler.sv
src/cp0_regfile.sv
src/exc_unit_top.sv
sim/tb_clkgen.sv
sim/tb_exc_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the exception unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module tb_exc_unit \
    -f sim.f -o tb_exc_unit > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_exc_unit > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Some tests failed" "$sim_log"; then
    exit 1
fi
exit 0

// File: sim/tb_exc_unit.sv
`timescale 1ns/1ps

module tb_exc_unit;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 1763;
    localparam int PRIO_ROUNDS  = 16;
    localparam int TIMER_CMP    = 8;
    localparam int RATE_CYCLES  = 20;
    // Cycle budget of each test, in run order
    localparam int TEST_CYCLES  = PRIO_ROUNDS + 4 + 28 + 8
                                  + (3 + 4 * TIMER_CMP + RATE_CYCLES) + 8;
    localparam int WATCHDOG_NS  = 2 * CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES);

    logic                    clk, rst_n;
    logic                    agu_valid, agu_slot, agu_store, bru_valid, eret_valid, eret_slot;
    mips_exc_pkg::addr_t     agu_addr, bru_target, slot1_pc, slot2_pc, redirect_pc;
    mips_exc_pkg::mem_size_t agu_size;
    logic                    slot1_en, slot1_ri, slot1_alu_ov, slot1_sys, slot1_brk;
    logic                    slot2_en, slot2_ri, slot2_alu_ov, slot2_sys, slot2_brk;
    mips_exc_pkg::fu_t       slot1_fu, slot2_fu;
    logic [5:0]              ext_int;
    logic                    mtc0_en;
    mips_exc_pkg::cp0_addr_t mtc0_addr, mfc0_addr;
    mips_exc_pkg::word_t     mtc0_data, mfc0_data;
    logic                    exception1_en, exception2_en, eret;
    int                      errors, checks, tests_run, test_err_base;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (.clk, .rst_n);

    exc_unit_top #(.COUNT_DIV(2)) u_dut (.*);

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        {agu_valid, agu_slot, agu_store, bru_valid, eret_valid, eret_slot} = '0;
        {slot1_en, slot1_ri, slot1_alu_ov, slot1_sys, slot1_brk} = '0;
        {slot2_en, slot2_ri, slot2_alu_ov, slot2_sys, slot2_brk} = '0;
        {agu_addr, bru_target, slot1_pc, slot2_pc} = '0;
        agu_size  = mips_exc_pkg::SIZE_BYTE;
        slot1_fu  = mips_exc_pkg::FU_ALU;
        slot2_fu  = mips_exc_pkg::FU_ALU;
        ext_int   = '0;
        mtc0_en   = 1'b0;
        mtc0_addr = '0;
        mtc0_data = '0;
        mfc0_addr = '0;
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic read_cp0(input mips_exc_pkg::cp0_addr_t addr,
                            output mips_exc_pkg::word_t data);
        mfc0_addr = addr;
        #1;
        data = mfc0_data;
    endtask

    task automatic expect_cp0(input string what, input mips_exc_pkg::cp0_addr_t addr,
                              input mips_exc_pkg::word_t exp);
        mips_exc_pkg::word_t rd;
        read_cp0(addr, rd);
        check_eq(what, rd, exp);
    endtask

    task automatic mtc0_write(input mips_exc_pkg::cp0_addr_t addr,
                              input mips_exc_pkg::word_t data);
        mtc0_en   = 1'b1;
        mtc0_addr = addr;
        mtc0_data = data;
        next_cycle();
        mtc0_en   = 1'b0;
    endtask

    task automatic check_strobes(input logic exp1, input logic exp2);
        check_bit("exception1_en", exception1_en, exp1);
        check_bit("exception2_en", exception2_en, exp2);
        if (exp1 || exp2)
            check_eq("redirect_pc", redirect_pc, mips_exc_pkg::EXC_VECTOR);
    endtask

    // ExcCode sits in Cause[6:2], BD in Cause[31]
    task automatic check_code(input mips_exc_pkg::ecode_t code, input logic exp_bd);
        mips_exc_pkg::word_t c;
        read_cp0(mips_exc_pkg::CP0_CAUSE, c);
        check_eq("Cause ExcCode", {27'b0, c[6:2]}, 32'(code));
        check_bit("Cause BD", c[31], exp_bd);
    endtask

    task automatic check_committed(input mips_exc_pkg::ecode_t code, input logic exp_bd,
                                   input mips_exc_pkg::addr_t exp_epc);
        check_code(code, exp_bd);
        expect_cp0("EPC", mips_exc_pkg::CP0_EPC, exp_epc);
    endtask

    // Highest-priority code of {ri, ov, sys, brk}
    function automatic mips_exc_pkg::ecode_t first_exc(input logic [3:0] f);
        mips_exc_pkg::ecode_t order [4] = '{mips_exc_pkg::EX_RI, mips_exc_pkg::EX_OV,
                                            mips_exc_pkg::EX_SYS, mips_exc_pkg::EX_BP};
        for (int i = 0; i < 4; i++)
            if (f[3 - i])
                return order[i];
        return mips_exc_pkg::EX_NONE;
    endfunction

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %-12s done, %0d error(s)", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic test_priority();
        logic [3:0]           f1, f2;
        mips_exc_pkg::ecode_t exp_code;
        mips_exc_pkg::addr_t  exp_epc;
        for (int n = 0; n < PRIO_ROUNDS; n++) begin
            f1 = (n % 3 == 0) ? 4'b0 : 4'($urandom);  // Let slot 2 win now and then
            f2 = 4'($urandom);
            slot1_en = 1'b1;
            slot2_en = 1'b1;
            slot1_pc = $urandom & ~32'h3;
            slot2_pc = slot1_pc + 32'd4;
            {slot1_ri, slot1_alu_ov, slot1_sys, slot1_brk} = f1;
            {slot2_ri, slot2_alu_ov, slot2_sys, slot2_brk} = f2;
            #2;
            check_strobes(f1 != 4'b0, f1 == 4'b0 && f2 != 4'b0);
            exp_code = (f1 != 4'b0) ? first_exc(f1) : first_exc(f2);
            exp_epc  = (f1 != 4'b0) ? slot1_pc : slot2_pc;
            next_cycle();
            idle_inputs();
            if (f1 != 4'b0 || f2 != 4'b0)
                check_committed(exp_code, 1'b0, exp_epc);
        end
    endtask

    task automatic test_delay_slot();
        mips_exc_pkg::addr_t pc2;
        for (int n = 0; n < 4; n++) begin
            pc2        = $urandom & ~32'h3;
            slot1_en   = 1'b1;
            slot2_en   = 1'b1;
            slot1_pc   = pc2 - 32'd4;
            slot2_pc   = pc2;
            slot1_fu   = n[0] ? mips_exc_pkg::FU_BRU : mips_exc_pkg::FU_ALU;
            bru_valid  = n[0];
            bru_target = $urandom & ~32'h3;
            slot2_sys  = 1'b1;
            #2;
            check_strobes(1'b0, 1'b1);
            next_cycle();
            idle_inputs();
            check_committed(mips_exc_pkg::EX_SYS, n[0], n[0] ? pc2 - 32'd4 : pc2);
        end
    endtask

    task automatic test_alignment();
        mips_exc_pkg::addr_t addr, exp_epc;
        logic                bad, in_slot2;
        for (int sz = 0; sz < 3; sz++)
            for (int off = 0; off < 4; off++)
                for (int st = 0; st < 2; st++) begin
                    addr     = ($urandom & ~32'h3) | 32'(off);
                    in_slot2 = 1'($urandom);
                    bad      = (sz == 1 && off[0]) || (sz == 2 && off != 0);
                    slot1_en = 1'b1;
                    slot2_en = 1'b1;
                    slot1_pc = $urandom & ~32'h3;
                    slot2_pc = slot1_pc + 32'd4;
                    slot1_fu = in_slot2 ? mips_exc_pkg::FU_ALU : mips_exc_pkg::FU_AGU;
                    slot2_fu = in_slot2 ? mips_exc_pkg::FU_AGU : mips_exc_pkg::FU_ALU;
                    agu_valid = 1'b1;
                    agu_slot  = in_slot2;
                    agu_addr  = addr;
                    agu_size  = mips_exc_pkg::mem_size_t'(sz);
                    agu_store = st[0];
                    #2;
                    check_strobes(bad && !in_slot2, bad && in_slot2);
                    exp_epc = in_slot2 ? slot2_pc : slot1_pc;
                    next_cycle();
                    idle_inputs();
                    if (bad) begin
                        check_committed(st[0] ? mips_exc_pkg::EX_ADES : mips_exc_pkg::EX_ADEL,
                                        1'b0, exp_epc);
                        expect_cp0("BadVAddr", mips_exc_pkg::CP0_BADVADDR, addr);
                    end
                end
        for (int off = 0; off < 4; off++) begin
            addr       = ($urandom & ~32'h3) | 32'(off);
            slot1_en   = 1'b1;
            slot1_pc   = $urandom & ~32'h3;
            slot1_fu   = mips_exc_pkg::FU_BRU;
            bru_valid  = 1'b1;
            bru_target = addr;
            #2;
            check_strobes(off != 0, 1'b0);
            next_cycle();
            idle_inputs();
            if (off != 0) begin
                check_code(mips_exc_pkg::EX_ADEL, 1'b0);
                expect_cp0("BadVAddr", mips_exc_pkg::CP0_BADVADDR, addr);
            end
        end
    endtask

    task automatic irq_cycle(input logic [5:0] lines, input logic exp_taken);
        mips_exc_pkg::addr_t pc;
        pc       = $urandom & ~32'h3;
        slot1_en = 1'b1;
        slot1_pc = pc;
        ext_int  = lines;
        #2;
        check_strobes(exp_taken, 1'b0);
        next_cycle();
        idle_inputs();
        if (exp_taken)
            check_committed(mips_exc_pkg::EX_INT, 1'b0, pc);
    endtask

    task automatic test_interrupts();
        int         k;
        logic [5:0] line;
        k    = int'($urandom % 6);
        line = 6'(1 << k);  // ext_int[k] is interrupt line k+2
        irq_cycle(line, 1'b0);  // EXL set by the earlier exceptions
        mtc0_write(mips_exc_pkg::CP0_STATUS, 32'h0);
        irq_cycle(line, 1'b0);
        mtc0_write(mips_exc_pkg::CP0_STATUS, (32'h1 << (10 + k)) | 32'h1);
        irq_cycle(6'(1 << ((k + 1) % 6)), 1'b0);
        irq_cycle(line, 1'b1);
        expect_cp0("Status", mips_exc_pkg::CP0_STATUS, (32'h1 << (10 + k)) | 32'h3);
        irq_cycle(line, 1'b0);
        mtc0_write(mips_exc_pkg::CP0_STATUS, 32'h2);
    endtask

    task automatic test_timer();
        mips_exc_pkg::word_t c0, c1, cause_now, count_now;
        logic                ti_seen;
        ti_seen = 1'b0;
        mtc0_write(mips_exc_pkg::CP0_COUNT, 32'h0);
        mtc0_write(mips_exc_pkg::CP0_COMPARE, 32'(TIMER_CMP));
        for (int n = 0; n < 4 * TIMER_CMP && !ti_seen; n++) begin
            read_cp0(mips_exc_pkg::CP0_CAUSE, cause_now);
            read_cp0(mips_exc_pkg::CP0_COUNT, count_now);
            ti_seen = cause_now[30];
            if (ti_seen)
                check_bit("Count at TI", count_now >= 32'(TIMER_CMP)
                          && count_now <= 32'(TIMER_CMP + 1), 1'b1);
            else
                check_bit("Count before TI", count_now <= 32'(TIMER_CMP), 1'b1);
            next_cycle();
        end
        checks++;
        assert (ti_seen) else begin
            $display("Cause TI never set after Count reached Compare");
            errors++;
        end
        read_cp0(mips_exc_pkg::CP0_COUNT, c0);
        repeat (RATE_CYCLES) next_cycle();
        read_cp0(mips_exc_pkg::CP0_COUNT, c1);
        check_bit("Count rate", (c1 - c0) >= 32'(RATE_CYCLES / 2 - 1)
                  && (c1 - c0) <= 32'(RATE_CYCLES / 2 + 1), 1'b1);
        mtc0_write(mips_exc_pkg::CP0_COMPARE, 32'h0);
        read_cp0(mips_exc_pkg::CP0_CAUSE, cause_now);
        check_bit("Cause TI after Compare write", cause_now[30], 1'b0);
    endtask

    task automatic test_eret();
        mips_exc_pkg::addr_t target;
        target = $urandom & ~32'h3;
        mtc0_write(mips_exc_pkg::CP0_EPC, target);
        slot1_en   = 1'b1;
        slot1_fu   = mips_exc_pkg::FU_COP0;
        eret_valid = 1'b1;
        #2;
        check_bit("eret", eret, 1'b1);
        check_strobes(1'b0, 1'b0);
        check_eq("redirect_pc", redirect_pc, target);
        next_cycle();
        idle_inputs();
        expect_cp0("Status", mips_exc_pkg::CP0_STATUS, 32'h0);
        for (int s = 0; s < 2; s++) begin
            target = ($urandom & ~32'h3) | 32'h2;
            mtc0_write(mips_exc_pkg::CP0_EPC, target);
            slot1_en   = 1'b1;
            slot2_en   = s[0];
            slot1_fu   = s[0] ? mips_exc_pkg::FU_ALU : mips_exc_pkg::FU_COP0;
            slot2_fu   = mips_exc_pkg::FU_COP0;
            eret_valid = 1'b1;
            eret_slot  = s[0];
            #2;
            check_bit("eret", eret, 1'b0);
            check_strobes(!s[0], s[0]);
            next_cycle();
            idle_inputs();
            check_code(mips_exc_pkg::EX_ADEL, 1'b0);
            expect_cp0("BadVAddr", mips_exc_pkg::CP0_BADVADDR, target);
            expect_cp0("Status", mips_exc_pkg::CP0_STATUS, 32'h2);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        test_err_base = 0;
        idle_inputs();
        wait (rst_n === 1'b1);
        next_cycle();
        test_priority();
        finish_test("priority");
        test_delay_slot();
        finish_test("delay_slot");
        test_alignment();
        finish_test("alignment");
        test_interrupts();
        finish_test("interrupts");
        test_timer();
        finish_test("timer");
        test_eret();
        finish_test("eret");
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;  // Released like any other input
    end

endmodule

// File: src/exc_unit_top.sv
`timescale 1ns/1ps

module exc_unit_top #(
    parameter int COUNT_DIV = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    agu_valid,
    input  logic                    agu_slot,
    input  mips_exc_pkg::addr_t     agu_addr,
    input  mips_exc_pkg::mem_size_t agu_size,
    input  logic                    agu_store,
    input  logic                    bru_valid,
    input  mips_exc_pkg::addr_t     bru_target,
    input  logic                    eret_valid,
    input  logic                    eret_slot,
    input  logic                    slot1_en,
    input  mips_exc_pkg::addr_t     slot1_pc,
    input  mips_exc_pkg::fu_t       slot1_fu,
    input  logic                    slot1_ri,
    input  logic                    slot1_alu_ov,
    input  logic                    slot1_sys,
    input  logic                    slot1_brk,
    input  logic                    slot2_en,
    input  mips_exc_pkg::addr_t     slot2_pc,
    input  mips_exc_pkg::fu_t       slot2_fu,
    input  logic                    slot2_ri,
    input  logic                    slot2_alu_ov,
    input  logic                    slot2_sys,
    input  logic                    slot2_brk,
    input  logic [5:0]              ext_int,
    input  logic                    mtc0_en,
    input  mips_exc_pkg::cp0_addr_t mtc0_addr,
    input  mips_exc_pkg::word_t     mtc0_data,
    input  mips_exc_pkg::cp0_addr_t mfc0_addr,
    output mips_exc_pkg::word_t     mfc0_data,
    output logic                    exception1_en,
    output logic                    exception2_en,
    output logic                    eret,
    output mips_exc_pkg::addr_t     redirect_pc
);
    exec_slot_if slot1 ();
    exec_slot_if slot2 ();
    exc_flags_if flags ();

    logic                 exception_en;
    logic                 bd;
    mips_exc_pkg::addr_t  epc;
    mips_exc_pkg::addr_t  bad_vaddr;
    mips_exc_pkg::ecode_t ecode;
    mips_exc_pkg::word_t  status;
    mips_exc_pkg::word_t  cause;
    mips_exc_pkg::addr_t  epc_value;

    assign slot1.en     = slot1_en;
    assign slot1.pc     = slot1_pc;
    assign slot1.fu     = slot1_fu;
    assign slot1.ri     = slot1_ri;
    assign slot1.alu_ov = slot1_alu_ov;
    assign slot1.sys    = slot1_sys;
    assign slot1.brk    = slot1_brk;

    assign slot2.en     = slot2_en;
    assign slot2.pc     = slot2_pc;
    assign slot2.fu     = slot2_fu;
    assign slot2.ri     = slot2_ri;
    assign slot2.alu_ov = slot2_alu_ov;
    assign slot2.sys    = slot2_sys;
    assign slot2.brk    = slot2_brk;

    exc_collector u_collector (
        .agu_valid  (agu_valid),
        .agu_slot   (agu_slot),
        .agu_addr   (agu_addr),
        .agu_size   (agu_size),
        .agu_store  (agu_store),
        .bru_valid  (bru_valid),
        .bru_target (bru_target),
        .eret_valid (eret_valid),
        .eret_slot  (eret_slot),
        .epc_value  (epc_value),
        .flags      (flags.src)
    );

    exhandler u_handler (
        .slot1         (slot1.dst),
        .slot2         (slot2.dst),
        .flags         (flags.dst),
        .agu_slot      (agu_slot),
        .status        (status),
        .cause         (cause),
        .ext_int       (ext_int),
        .exception1_en (exception1_en),
        .exception2_en (exception2_en),
        .eret          (eret),
        .redirect_pc   (redirect_pc),
        .exception_en  (exception_en),
        .bd            (bd),
        .epc           (epc),
        .bad_vaddr     (bad_vaddr),
        .ecode         (ecode)
    );

    cp0_regfile #(
        .COUNT_DIV (COUNT_DIV)
    ) u_cp0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mtc0_en      (mtc0_en),
        .mtc0_addr    (mtc0_addr),
        .mtc0_data    (mtc0_data),
        .mfc0_addr    (mfc0_addr),
        .mfc0_data    (mfc0_data),
        .exception_en (exception_en),
        .bd           (bd),
        .epc          (epc),
        .bad_vaddr    (bad_vaddr),
        .ecode        (ecode),
        .eret         (eret),
        .status       (status),
        .cause        (cause),
        .epc_value    (epc_value)
    );

endmodule

// File: src/cp0_regfile.sv
`timescale 1ns/1ps

module cp0_regfile #(
    parameter int COUNT_DIV = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mtc0_en,
    input  mips_exc_pkg::cp0_addr_t  mtc0_addr,
    input  mips_exc_pkg::word_t      mtc0_data,
    input  mips_exc_pkg::cp0_addr_t  mfc0_addr,
    output mips_exc_pkg::word_t      mfc0_data,
    input  logic                     exception_en,
    input  logic                     bd,
    input  mips_exc_pkg::addr_t      epc,
    input  mips_exc_pkg::addr_t      bad_vaddr,
    input  mips_exc_pkg::ecode_t     ecode,
    input  logic                     eret,
    output mips_exc_pkg::word_t      status,
    output mips_exc_pkg::word_t      cause,
    output mips_exc_pkg::addr_t      epc_value
);
    localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(COUNT_DIV - 1);

    logic                ie_q;
    logic                exl_q;
    logic [7:0]          im_q;
    logic                bd_q;
    logic                ti_q;
    logic [1:0]          ip_sw_q;
    logic [4:0]          exc_code_q;
    mips_exc_pkg::addr_t epc_q;
    mips_exc_pkg::addr_t badvaddr_q;
    mips_exc_pkg::word_t count_q;
    mips_exc_pkg::word_t compare_q;
    logic [DIV_W-1:0]    div_q;
    logic                mtc0_we;
    logic                bad_addr_exc;

    // Exception beats MTC0 in the same cycle
    assign mtc0_we      = mtc0_en && !exception_en;
    assign bad_addr_exc = ecode == mips_exc_pkg::EX_ADEL || ecode == mips_exc_pkg::EX_ADES;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ie_q       <= 1'b0;
            exl_q      <= 1'b1;
            im_q       <= '0;
            bd_q       <= 1'b0;
            ti_q       <= 1'b0;
            ip_sw_q    <= '0;
            exc_code_q <= '0;
            count_q    <= '0;
            compare_q  <= '0;
            div_q      <= '0;
        end else begin
            div_q <= (div_q == DIV_LAST) ? '0 : div_q + 1'b1;
            if (div_q == DIV_LAST)
                count_q <= count_q + 32'd1;
            if (compare_q != '0 && count_q == compare_q)
                ti_q <= 1'b1;

            if (exception_en) begin
                exl_q      <= 1'b1;
                bd_q       <= bd;
                exc_code_q <= ecode;
            end else if (eret) begin
                exl_q <= 1'b0;
            end else if (mtc0_we) begin
                case (mtc0_addr)
                    mips_exc_pkg::CP0_STATUS: begin
                        ie_q  <= mtc0_data[mips_exc_pkg::STATUS_IE];
                        exl_q <= mtc0_data[mips_exc_pkg::STATUS_EXL];
                        im_q  <= mtc0_data[mips_exc_pkg::STATUS_IM_HI:mips_exc_pkg::STATUS_IM_LO];
                    end
                    mips_exc_pkg::CP0_CAUSE:
                        ip_sw_q <= mtc0_data[mips_exc_pkg::CAUSE_IP_LO+1:mips_exc_pkg::CAUSE_IP_LO];
                    mips_exc_pkg::CP0_COUNT:   count_q <= mtc0_data;
                    mips_exc_pkg::CP0_COMPARE: begin
                        compare_q <= mtc0_data;
                        ti_q      <= 1'b0;  // Acknowledges the timer
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exception_en) begin
            epc_q <= epc;
            if (bad_addr_exc)
                badvaddr_q <= bad_vaddr;
        end else if (mtc0_we && mtc0_addr == mips_exc_pkg::CP0_EPC) begin
            epc_q <= mtc0_data;
        end
    end

    always_comb begin
        status = '0;
        status[mips_exc_pkg::STATUS_IE]  = ie_q;
        status[mips_exc_pkg::STATUS_EXL] = exl_q;
        status[mips_exc_pkg::STATUS_IM_HI:mips_exc_pkg::STATUS_IM_LO] = im_q;

        cause = '0;
        cause[mips_exc_pkg::CAUSE_BD] = bd_q;
        cause[mips_exc_pkg::CAUSE_TI] = ti_q;
        cause[mips_exc_pkg::CAUSE_IP_LO+1:mips_exc_pkg::CAUSE_IP_LO]  = ip_sw_q;
        cause[mips_exc_pkg::CAUSE_EXC_HI:mips_exc_pkg::CAUSE_EXC_LO] = exc_code_q;
    end

    assign epc_value = epc_q;

    always_comb begin
        case (mfc0_addr)
            mips_exc_pkg::CP0_BADVADDR: mfc0_data = badvaddr_q;
            mips_exc_pkg::CP0_COUNT:    mfc0_data = count_q;
            mips_exc_pkg::CP0_COMPARE:  mfc0_data = compare_q;
            mips_exc_pkg::CP0_STATUS:   mfc0_data = status;
            mips_exc_pkg::CP0_CAUSE:    mfc0_data = cause;
            mips_exc_pkg::CP0_EPC:      mfc0_data = epc_q;
            default:                    mfc0_data = '0;
        endcase
    end

endmodule

// File: src/exhandler.sv
`timescale 1ns/1ps

module exhandler (
    exec_slot_if.dst              slot1,
    exec_slot_if.dst              slot2,
    exc_flags_if.dst              flags,
    input  logic                  agu_slot,
    input  mips_exc_pkg::word_t   status,
    input  mips_exc_pkg::word_t   cause,
    input  logic [5:0]            ext_int,
    output logic                  exception1_en,
    output logic                  exception2_en,
    output logic                  eret,
    output mips_exc_pkg::addr_t   redirect_pc,
    output logic                  exception_en,
    output logic                  bd,
    output mips_exc_pkg::addr_t   epc,
    output mips_exc_pkg::addr_t   bad_vaddr,
    output mips_exc_pkg::ecode_t  ecode
);
    logic [7:0]           irq_lines;
    logic                 int_pending;
    mips_exc_pkg::ecode_t slot1_code;
    mips_exc_pkg::ecode_t slot2_code;
    logic                 slot2_exc;

    // Per-slot order after the ERET check
    function automatic mips_exc_pkg::ecode_t slot_code(
        input logic ri,
        input logic ov,
        input logic sys,
        input logic brk,
        input logic adel,
        input logic ades
    );
        if (ri)
            return mips_exc_pkg::EX_RI;
        else if (ov)
            return mips_exc_pkg::EX_OV;
        else if (sys)
            return mips_exc_pkg::EX_SYS;
        else if (brk)
            return mips_exc_pkg::EX_BP;
        else if (adel)
            return mips_exc_pkg::EX_ADEL;
        else if (ades)
            return mips_exc_pkg::EX_ADES;
        return mips_exc_pkg::EX_NONE;
    endfunction

    assign irq_lines = ({ext_int, cause[mips_exc_pkg::CAUSE_IP_LO+1:mips_exc_pkg::CAUSE_IP_LO]}
                        | {cause[mips_exc_pkg::CAUSE_TI], 7'b0})
                       & status[mips_exc_pkg::STATUS_IM_HI:mips_exc_pkg::STATUS_IM_LO];
    assign int_pending = |irq_lines && slot1.en && !status[mips_exc_pkg::STATUS_EXL];

    assign slot1_code = slot_code(slot1.ri, slot1.alu_ov, slot1.sys, slot1.brk,
                                  flags.agu_adel && !agu_slot, flags.agu_ades && !agu_slot);
    assign slot2_code = slot_code(slot2.ri, slot2.alu_ov, slot2.sys, slot2.brk,
                                  flags.agu_adel && agu_slot, flags.agu_ades && agu_slot);
    assign slot2_exc  = slot2.en && (slot2_code != mips_exc_pkg::EX_NONE
                                     || (flags.cop0_adel && flags.cop0_second));

    always_comb begin
        exception1_en = 1'b0;
        exception2_en = 1'b0;
        bd            = 1'b0;
        epc           = '0;
        bad_vaddr     = '0;
        ecode         = mips_exc_pkg::EX_NONE;

        if (int_pending) begin
            exception1_en = 1'b1;
            epc           = slot1.pc;
            ecode         = mips_exc_pkg::EX_INT;
        end else if (slot1.en && flags.bru_adel && !slot2_exc) begin
            exception1_en = 1'b1;
            epc           = flags.bru_badvaddr;  // Fault is at the target itself
            bad_vaddr     = flags.bru_badvaddr;
            ecode         = mips_exc_pkg::EX_ADEL;
        end else if (slot1.en && flags.cop0_adel && flags.cop0_first) begin
            exception1_en = 1'b1;
            epc           = flags.cop0_badvaddr;
            bad_vaddr     = flags.cop0_badvaddr;
            ecode         = mips_exc_pkg::EX_ADEL;
        end else if (slot1.en && slot1_code != mips_exc_pkg::EX_NONE) begin
            exception1_en = 1'b1;
            epc           = slot1.pc;
            bad_vaddr     = flags.agu_badvaddr;
            ecode         = slot1_code;
        end else if (slot2.en && flags.cop0_adel && flags.cop0_second) begin
            exception2_en = 1'b1;
            epc           = flags.cop0_badvaddr;
            bad_vaddr     = flags.cop0_badvaddr;
            ecode         = mips_exc_pkg::EX_ADEL;
        end else if (slot2.en && slot2_code != mips_exc_pkg::EX_NONE) begin
            exception2_en = 1'b1;
            epc           = slot2.pc;
            bad_vaddr     = flags.agu_badvaddr;
            ecode         = slot2_code;
            if (slot1.fu == mips_exc_pkg::FU_BRU) begin  // Delay slot
                epc = slot2.pc - 32'd4;
                bd  = 1'b1;
            end
        end
    end

    assign exception_en = exception1_en | exception2_en;
    assign eret         = flags.cop0_eret && !exception_en;

    // Collector forwards the current EPC on cop0_badvaddr
    assign redirect_pc = exception_en ? mips_exc_pkg::EXC_VECTOR : flags.cop0_badvaddr;

endmodule

// File: src/exc_collector.sv
`timescale 1ns/1ps

module exc_collector (
    input  logic                    agu_valid,
    input  logic                    agu_slot,
    input  mips_exc_pkg::addr_t     agu_addr,
    input  mips_exc_pkg::mem_size_t agu_size,
    input  logic                    agu_store,
    input  logic                    bru_valid,
    input  mips_exc_pkg::addr_t     bru_target,
    input  logic                    eret_valid,
    input  logic                    eret_slot,
    input  mips_exc_pkg::addr_t     epc_value,
    exc_flags_if.src                flags
);
    logic agu_misaligned;
    logic agu_fault;
    logic eret_misaligned;

    always_comb begin
        case (agu_size)
            mips_exc_pkg::SIZE_HALF: agu_misaligned = agu_addr[0];
            mips_exc_pkg::SIZE_WORD: agu_misaligned = |agu_addr[1:0];
            default:                 agu_misaligned = 1'b0;  // Bytes never fault
        endcase
    end

    // A slot holding the ERET has no memory access
    assign agu_fault = agu_valid && agu_misaligned
                       && !(eret_valid && eret_slot == agu_slot);

    assign flags.agu_adel     = agu_fault && !agu_store;
    assign flags.agu_ades     = agu_fault && agu_store;
    assign flags.agu_badvaddr = agu_addr;

    assign flags.bru_adel     = bru_valid && |bru_target[1:0];
    assign flags.bru_badvaddr = bru_target;

    // ERET returns to EPC
    assign eret_misaligned     = |epc_value[1:0];
    assign flags.cop0_adel     = eret_valid && eret_misaligned;
    assign flags.cop0_first    = eret_valid && !eret_slot;
    assign flags.cop0_second   = eret_valid && eret_slot;
    assign flags.cop0_badvaddr = epc_value;
    assign flags.cop0_eret     = eret_valid && !eret_misaligned;

endmodule

// File: src/exc_flags_if.sv
`timescale 1ns/1ps

interface exc_flags_if;
    logic                bru_adel;
    mips_exc_pkg::addr_t bru_badvaddr;
    logic                agu_adel;
    logic                agu_ades;
    mips_exc_pkg::addr_t agu_badvaddr;
    logic                cop0_adel;    // ERET to a misaligned EPC
    logic                cop0_first;
    logic                cop0_second;
    mips_exc_pkg::addr_t cop0_badvaddr;
    logic                cop0_eret;    // Clean ERET

    modport src (
        output bru_adel, bru_badvaddr,
        output agu_adel, agu_ades, agu_badvaddr,
        output cop0_adel, cop0_first, cop0_second, cop0_badvaddr,
        output cop0_eret
    );

    modport dst (
        input bru_adel, bru_badvaddr,
        input agu_adel, agu_ades, agu_badvaddr,
        input cop0_adel, cop0_first, cop0_second, cop0_badvaddr,
        input cop0_eret
    );

endinterface

// File: src/exec_slot_if.sv
`timescale 1ns/1ps

interface exec_slot_if;
    logic                en;
    mips_exc_pkg::addr_t pc;
    mips_exc_pkg::fu_t   fu;
    logic                ri;      // Reserved instruction
    logic                alu_ov;
    logic                sys;
    logic                brk;

    modport src (
        output en, pc, fu, ri, alu_ov, sys, brk
    );

    modport dst (
        input en, pc, fu, ri, alu_ov, sys, brk
    );

endinterface

// File: src/mips_exc_pkg.sv
package mips_exc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  cp0_addr_t;

    // Cause ExcCode values
    typedef enum logic [4:0] {
        EX_INT  = 5'd0,
        EX_ADEL = 5'd4,
        EX_ADES = 5'd5,
        EX_SYS  = 5'd8,
        EX_BP   = 5'd9,
        EX_RI   = 5'd10,
        EX_OV   = 5'd12,
        EX_NONE = 5'd31  // Idle
    } ecode_t;

    typedef enum logic [2:0] {
        FU_ALU,
        FU_BRU,
        FU_AGU,
        FU_COP0,
        FU_MDU
    } fu_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_t;

    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    localparam addr_t EXC_VECTOR = 32'hBFC0_0380;  // Boot-time general vector

    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;

    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_IP_LO  = 8;   // IP[1:0] are the software bits
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_TI     = 30;
    localparam int CAUSE_BD     = 31;

endpackage
